//--- source/fdiv_cfg.svh
`ifndef FDIV_CFG_SVH
`define FDIV_CFG_SVH

`define FDIV_TAG_W 5
`define FDIV_BIAS 127
`define FDIV_EXP_W 10

// Significand width with the hidden bit restored.
`define FDIV_MANT_W 24

// One integer bit, 23 fraction bits, guard and round. Also the iteration count.
`define FDIV_QUOT_W 26

`define FDIV_CANON_NAN 32'h7fc0_0000

`endif

//--- source/fdiv_pkg.sv
`include "fdiv_cfg.svh"

package fdiv_pkg;

    typedef enum logic [1:0] {
        RNE = 2'd0, // Nearest, ties to even.
        RTZ = 2'd1,
        RDN = 2'd2,
        RUP = 2'd3
    } fdiv_round_e;

    typedef enum logic [2:0] {
        CLASS_ZERO   = 3'd0, // Subnormals land here too.
        CLASS_NORMAL = 3'd1,
        CLASS_INF    = 3'd2,
        CLASS_QNAN   = 3'd3,
        CLASS_SNAN   = 3'd4
    } fdiv_class_e;

    typedef enum logic [2:0] {
        SPEC_NONE    = 3'd0,
        SPEC_INVALID = 3'd1,
        SPEC_QNAN    = 3'd2,
        SPEC_INF     = 3'd3,
        SPEC_DZ_INF  = 3'd4,
        SPEC_ZERO    = 3'd5
    } fdiv_special_e;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_DONE = 2'd2
    } fdiv_div_state_e;

    typedef struct packed {
        logic [`FDIV_TAG_W-1:0] tag;
        logic [31:0]            a;
        logic [31:0]            b;
        fdiv_round_e            mode;
    } fdiv_cmd_t;

    typedef struct packed {
        logic [`FDIV_TAG_W-1:0]  tag;
        fdiv_round_e             mode;
        logic                    sign;
        fdiv_class_e             class_a;
        fdiv_class_e             class_b;
        logic [7:0]              exp_a;
        logic [7:0]              exp_b;
        logic [`FDIV_MANT_W-1:0] mant_a;
        logic [`FDIV_MANT_W-1:0] mant_b;
    } fdiv_dec_t;

    typedef struct packed {
        logic [`FDIV_TAG_W-1:0]        tag;
        fdiv_round_e                   mode;
        logic                          sign;
        fdiv_special_e                 special;
        logic signed [`FDIV_EXP_W-1:0] exp; // Unbiased.
        logic [`FDIV_MANT_W-1:0]       mant_a;
        logic [`FDIV_MANT_W-1:0]       mant_b;
    } fdiv_exp_t;

    typedef struct packed {
        logic [`FDIV_TAG_W-1:0]        tag;
        fdiv_round_e                   mode;
        logic                          sign;
        fdiv_special_e                 special;
        logic signed [`FDIV_EXP_W-1:0] exp;
        logic [`FDIV_QUOT_W-1:0]       quot;
        logic                          sticky;
    } fdiv_quot_t;

    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fdiv_flags_t;

    typedef struct packed {
        logic [`FDIV_TAG_W-1:0] tag;
        logic [31:0]            value;
        fdiv_flags_t            flags;
    } fdiv_result_t;

endpackage

//--- source/fdiv_operand_decode.sv
`timescale 1ns/10ps

module fdiv_operand_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  fdiv_pkg::fdiv_cmd_t in,
    output logic                out_valid,
    input  logic                out_ready,
    output fdiv_pkg::fdiv_dec_t out
);

    fdiv_pkg::fdiv_dec_t next_dec;

    function automatic fdiv_pkg::fdiv_class_e classify(input logic [7:0] exp_f,
                                                       input logic [22:0] frac_f);
        fdiv_pkg::fdiv_class_e cls;
        if (exp_f == 8'd0) begin
            cls = fdiv_pkg::CLASS_ZERO; // Flush to zero.
        end else if (exp_f != 8'hff) begin
            cls = fdiv_pkg::CLASS_NORMAL;
        end else if (frac_f == 23'd0) begin
            cls = fdiv_pkg::CLASS_INF;
        end else if (frac_f[22]) begin
            cls = fdiv_pkg::CLASS_QNAN;
        end else begin
            cls = fdiv_pkg::CLASS_SNAN;
        end
        return cls;
    endfunction

    always_comb begin
        next_dec.tag     = in.tag;
        next_dec.mode    = in.mode;
        next_dec.sign    = in.a[31] ^ in.b[31];
        next_dec.class_a = classify(in.a[30:23], in.a[22:0]);
        next_dec.class_b = classify(in.b[30:23], in.b[22:0]);
        next_dec.exp_a   = in.a[30:23];
        next_dec.exp_b   = in.b[30:23];
        next_dec.mant_a  = {|in.a[30:23], in.a[22:0]}; // Hidden bit.
        next_dec.mant_b  = {|in.b[30:23], in.b[22:0]};
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out <= next_dec;
        end
    end

    hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out));

endmodule

//--- source/fdiv_exponent.sv
`timescale 1ns/10ps
`include "fdiv_cfg.svh"

module fdiv_exponent (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  fdiv_pkg::fdiv_dec_t in,
    output logic                out_valid,
    input  logic                out_ready,
    output fdiv_pkg::fdiv_exp_t out
);

    localparam int EXP_W = `FDIV_EXP_W;

    logic signed [EXP_W-1:0] exp_a_ext;
    logic signed [EXP_W-1:0] exp_b_ext;
    fdiv_pkg::fdiv_exp_t     next_exp;

    function automatic fdiv_pkg::fdiv_special_e resolve(input fdiv_pkg::fdiv_class_e ca,
                                                        input fdiv_pkg::fdiv_class_e cb);
        logic any_snan;
        logic any_qnan;
        fdiv_pkg::fdiv_special_e spec;
        any_snan = (ca == fdiv_pkg::CLASS_SNAN) || (cb == fdiv_pkg::CLASS_SNAN);
        any_qnan = (ca == fdiv_pkg::CLASS_QNAN) || (cb == fdiv_pkg::CLASS_QNAN);
        if (any_snan || (ca == fdiv_pkg::CLASS_ZERO && cb == fdiv_pkg::CLASS_ZERO)
                || (ca == fdiv_pkg::CLASS_INF && cb == fdiv_pkg::CLASS_INF)) begin
            spec = fdiv_pkg::SPEC_INVALID;
        end else if (any_qnan) begin
            spec = fdiv_pkg::SPEC_QNAN;
        end else if (ca == fdiv_pkg::CLASS_INF) begin
            spec = fdiv_pkg::SPEC_INF;
        end else if (ca == fdiv_pkg::CLASS_NORMAL && cb == fdiv_pkg::CLASS_ZERO) begin
            spec = fdiv_pkg::SPEC_DZ_INF;
        end else if (ca == fdiv_pkg::CLASS_ZERO || cb == fdiv_pkg::CLASS_INF) begin
            spec = fdiv_pkg::SPEC_ZERO;
        end else begin
            spec = fdiv_pkg::SPEC_NONE;
        end
        return spec;
    endfunction

    assign exp_a_ext = {{(EXP_W-8){1'b0}}, in.exp_a};
    assign exp_b_ext = {{(EXP_W-8){1'b0}}, in.exp_b};

    always_comb begin
        next_exp.tag     = in.tag;
        next_exp.mode    = in.mode;
        next_exp.sign    = in.sign;
        next_exp.special = resolve(in.class_a, in.class_b);
        next_exp.exp     = exp_a_ext - exp_b_ext; // Biases cancel.
        next_exp.mant_a  = in.mant_a;
        next_exp.mant_b  = in.mant_b;
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out <= next_exp;
        end
    end

    hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out));

endmodule

//--- source/fdiv_mantissa_divide.sv
`timescale 1ns/10ps
`include "fdiv_cfg.svh"

module fdiv_mantissa_divide (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  fdiv_pkg::fdiv_exp_t  in,
    output logic                 out_valid,
    input  logic                 out_ready,
    output fdiv_pkg::fdiv_quot_t out
);

    localparam int QUOT_W = `FDIV_QUOT_W;
    localparam int MANT_W = `FDIV_MANT_W;
    localparam int EXP_W  = `FDIV_EXP_W;
    localparam int REM_W  = MANT_W + 1; // Remainder stays below twice the divisor.
    localparam int CNT_W  = $clog2(QUOT_W + 1);

    fdiv_pkg::fdiv_div_state_e state;
    logic [CNT_W-1:0]          count;
    logic [REM_W-1:0]          rem_q;
    logic [MANT_W-1:0]         div_q;
    logic [REM_W-1:0]          rem_sub;
    logic [REM_W-1:0]          rem_next;
    logic                      q_bit;
    logic                      accept;
    logic                      a_lt_b;
    logic                      last_step;

    assign in_ready  = (state == fdiv_pkg::DIV_IDLE) || (state == fdiv_pkg::DIV_DONE && out_ready);
    assign out_valid = (state == fdiv_pkg::DIV_DONE);
    assign accept    = in_valid && in_ready;
    assign a_lt_b    = in.mant_a < in.mant_b;
    assign last_step = (count == CNT_W'(QUOT_W));

    assign q_bit    = rem_q >= {1'b0, div_q};
    assign rem_sub  = rem_q - {1'b0, div_q};
    assign rem_next = q_bit ? rem_sub : rem_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= fdiv_pkg::DIV_IDLE;
            count <= '0;
        end else if (accept) begin
            state <= (in.special == fdiv_pkg::SPEC_NONE) ? fdiv_pkg::DIV_RUN
                                                          : fdiv_pkg::DIV_DONE;
            count <= '0;
        end else if (state == fdiv_pkg::DIV_RUN) begin
            if (last_step) begin
                state <= fdiv_pkg::DIV_DONE; // Extra cycle to form sticky.
            end else begin
                count <= count + 1'b1;
            end
        end else if (state == fdiv_pkg::DIV_DONE && out_ready) begin
            state <= fdiv_pkg::DIV_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out.tag     <= in.tag;
            out.mode    <= in.mode;
            out.sign    <= in.sign;
            out.special <= in.special;
            out.exp     <= a_lt_b ? in.exp - EXP_W'(1) : in.exp; // Quotient lands in [1,2).
            out.quot    <= '0;
            out.sticky  <= 1'b0;
            rem_q       <= a_lt_b ? {in.mant_a, 1'b0} : {1'b0, in.mant_a};
            div_q       <= in.mant_b;
        end else if (state == fdiv_pkg::DIV_RUN) begin
            if (last_step) begin
                out.sticky <= |rem_q;
            end else begin
                out.quot <= {out.quot[QUOT_W-2:0], q_bit};
                rem_q    <= {rem_next[REM_W-2:0], 1'b0};
            end
        end
    end

    // Ordinary commands stall the input for the whole run, then present the result.
    run_latency: assert property (@(posedge clk) disable iff (!rst_n)
        accept && in.special == fdiv_pkg::SPEC_NONE
        |=> (!in_ready && state == fdiv_pkg::DIV_RUN) [*(QUOT_W + 1)] ##1 out_valid);

endmodule

//--- source/fdiv_round_pack.sv
`timescale 1ns/10ps
`include "fdiv_cfg.svh"

module fdiv_round_pack (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  fdiv_pkg::fdiv_quot_t   in,
    output logic                   out_valid,
    input  logic                   out_ready,
    output fdiv_pkg::fdiv_result_t out
);

    localparam int EXP_W  = `FDIV_EXP_W;
    localparam int MANT_W = `FDIV_MANT_W;
    localparam int QUOT_W = `FDIV_QUOT_W;

    localparam logic signed [EXP_W-1:0] BIAS    = EXP_W'(`FDIV_BIAS);
    localparam logic signed [EXP_W-1:0] EXP_MAX = EXP_W'(255);

    logic [MANT_W-1:0]       sig;
    logic                    guard;
    logic                    rnd;
    logic                    inexact;
    logic                    round_up;
    logic [MANT_W:0]         sig_inc;
    logic [MANT_W-1:0]       sig_fin;
    logic signed [EXP_W-1:0] exp_biased;
    logic                    use_max;
    fdiv_pkg::fdiv_result_t  next_res;

    assign sig     = in.quot[QUOT_W-1:2];
    assign guard   = in.quot[1];
    assign rnd     = in.quot[0];
    assign inexact = guard || rnd || in.sticky;

    always_comb begin
        case (in.mode)
            fdiv_pkg::RNE: round_up = guard && (rnd || in.sticky || sig[0]);
            fdiv_pkg::RDN: round_up = inexact && in.sign;
            fdiv_pkg::RUP: round_up = inexact && !in.sign;
            default:       round_up = 1'b0;
        endcase
    end

    assign sig_inc    = {1'b0, sig} + {{MANT_W{1'b0}}, round_up};
    assign sig_fin    = sig_inc[MANT_W] ? sig_inc[MANT_W:1] : sig_inc[MANT_W-1:0];
    assign exp_biased = in.exp + BIAS + $signed({{(EXP_W-1){1'b0}}, sig_inc[MANT_W]});
    assign use_max    = (in.mode == fdiv_pkg::RTZ) || (in.mode == fdiv_pkg::RDN && !in.sign)
                        || (in.mode == fdiv_pkg::RUP && in.sign);

    always_comb begin
        next_res.tag   = in.tag;
        next_res.flags = '0;
        case (in.special)
            fdiv_pkg::SPEC_INVALID: begin
                next_res.value    = `FDIV_CANON_NAN;
                next_res.flags.nv = 1'b1;
            end
            fdiv_pkg::SPEC_QNAN: next_res.value = `FDIV_CANON_NAN;
            fdiv_pkg::SPEC_INF:  next_res.value = {in.sign, 8'hff, 23'd0};
            fdiv_pkg::SPEC_DZ_INF: begin
                next_res.value    = {in.sign, 8'hff, 23'd0};
                next_res.flags.dz = 1'b1;
            end
            fdiv_pkg::SPEC_ZERO: next_res.value = {in.sign, 31'd0};
            default: begin
                next_res.flags.nx = inexact;
                if (exp_biased >= EXP_MAX) begin
                    next_res.value    = use_max ? {in.sign, 8'hfe, 23'h7f_ffff}
                                                : {in.sign, 8'hff, 23'd0};
                    next_res.flags.of = 1'b1;
                    next_res.flags.nx = 1'b1;
                end else if (exp_biased <= 0) begin
                    next_res.value    = {in.sign, 31'd0}; // Flush to zero.
                    next_res.flags.uf = 1'b1;
                    next_res.flags.nx = 1'b1;
                end else begin
                    next_res.value = {in.sign, exp_biased[7:0], sig_fin[MANT_W-2:0]};
                end
            end
        endcase
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out <= next_res;
        end
    end

endmodule

//--- source/fdiv_unit.sv
`timescale 1ns/10ps

module fdiv_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  fdiv_pkg::fdiv_cmd_t    cmd,
    output logic                   res_valid,
    input  logic                   res_ready,
    output fdiv_pkg::fdiv_result_t res
);

    logic                 dec_valid;
    logic                 dec_ready;
    fdiv_pkg::fdiv_dec_t  dec;
    logic                 exp_valid;
    logic                 exp_ready;
    fdiv_pkg::fdiv_exp_t  exp_out;
    logic                 quot_valid;
    logic                 quot_ready;
    fdiv_pkg::fdiv_quot_t quot;

    fdiv_operand_decode i_operand_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (cmd_valid),
        .in_ready  (cmd_ready),
        .in        (cmd),
        .out_valid (dec_valid),
        .out_ready (dec_ready),
        .out       (dec)
    );

    fdiv_exponent i_exponent (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (dec_valid),
        .in_ready  (dec_ready),
        .in        (dec),
        .out_valid (exp_valid),
        .out_ready (exp_ready),
        .out       (exp_out)
    );

    fdiv_mantissa_divide i_mantissa_divide (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (exp_valid),
        .in_ready  (exp_ready),
        .in        (exp_out),
        .out_valid (quot_valid),
        .out_ready (quot_ready),
        .out       (quot)
    );

    fdiv_round_pack i_round_pack (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (quot_valid),
        .in_ready  (quot_ready),
        .in        (quot),
        .out_valid (res_valid),
        .out_ready (res_ready),
        .out       (res)
    );

endmodule

//--- test/fdiv_tb.sv
`timescale 1ns/10ps
`include "fdiv_cfg.svh"

module fdiv_tb;

    logic                   clk;
    logic                   rst_n;
    logic                   cmd_valid;
    logic                   cmd_ready;
    fdiv_pkg::fdiv_cmd_t    cmd;
    logic                   res_valid;
    logic                   res_ready;
    fdiv_pkg::fdiv_result_t res;

    integer                 seed;
    logic                   random_ready;
    logic                   random_gaps;
    logic                   next_ready;
    logic                   stall_seen;
    logic [`FDIV_TAG_W-1:0] next_tag;
    fdiv_pkg::fdiv_result_t held_res;
    fdiv_pkg::fdiv_result_t expected_q [$];

    fdiv_unit i_fdiv_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res       (res)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t: %s expected 0x%08h, actual 0x%08h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic compare_flags(input string name, input fdiv_pkg::fdiv_flags_t expected,
                                 input fdiv_pkg::fdiv_flags_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t: %s expected %b, actual %b (nv dz of uf nx)",
                                $time, name, expected, actual));
        end
    endtask

    function automatic fdiv_pkg::fdiv_class_e operand_class(input logic [31:0] x);
        fdiv_pkg::fdiv_class_e c;
        if (x[30:23] == 8'h00) begin
            c = fdiv_pkg::CLASS_ZERO; // Subnormals count as zero.
        end else if (x[30:23] != 8'hff) begin
            c = fdiv_pkg::CLASS_NORMAL;
        end else if (x[22:0] == 23'd0) begin
            c = fdiv_pkg::CLASS_INF;
        end else if (x[22]) begin
            c = fdiv_pkg::CLASS_QNAN;
        end else begin
            c = fdiv_pkg::CLASS_SNAN;
        end
        return c;
    endfunction

    function automatic fdiv_pkg::fdiv_result_t model_divide(input fdiv_pkg::fdiv_cmd_t c);
        fdiv_pkg::fdiv_result_t r;
        fdiv_pkg::fdiv_class_e  ca;
        fdiv_pkg::fdiv_class_e  cb;
        logic                   sign;
        logic                   guard;
        logic                   rnd;
        logic                   sticky;
        logic                   inexact;
        logic                   up;
        longint unsigned        ma;
        longint unsigned        mb;
        longint unsigned        num;
        longint unsigned        q;
        longint unsigned        sig;
        int                     biased;
        r.tag   = c.tag;
        r.value = '0;
        r.flags = '0;
        sign    = c.a[31] ^ c.b[31];
        ca      = operand_class(c.a);
        cb      = operand_class(c.b);
        if (ca == fdiv_pkg::CLASS_SNAN || cb == fdiv_pkg::CLASS_SNAN
                || (ca == fdiv_pkg::CLASS_ZERO && cb == fdiv_pkg::CLASS_ZERO)
                || (ca == fdiv_pkg::CLASS_INF && cb == fdiv_pkg::CLASS_INF)) begin
            r.value    = `FDIV_CANON_NAN;
            r.flags.nv = 1'b1;
        end else if (ca == fdiv_pkg::CLASS_QNAN || cb == fdiv_pkg::CLASS_QNAN) begin
            r.value = `FDIV_CANON_NAN;
        end else if (ca == fdiv_pkg::CLASS_INF) begin
            r.value = {sign, 8'hff, 23'd0};
        end else if (cb == fdiv_pkg::CLASS_ZERO) begin
            r.value    = {sign, 8'hff, 23'd0};
            r.flags.dz = 1'b1;
        end else if (ca == fdiv_pkg::CLASS_ZERO || cb == fdiv_pkg::CLASS_INF) begin
            r.value = {sign, 31'd0};
        end else begin
            ma     = 64'h80_0000 | c.a[22:0];
            mb     = 64'h80_0000 | c.b[22:0];
            biased = int'(c.a[30:23]) - int'(c.b[30:23]) + `FDIV_BIAS;
            if (ma < mb) begin
                num    = ma << 26; // Scale so the quotient sits in [2^25, 2^26).
                biased = biased - 1;
            end else begin
                num = ma << 25;
            end
            q       = num / mb;
            sticky  = (num % mb) != 0;
            sig     = q >> 2;
            guard   = q[1];
            rnd     = q[0];
            inexact = guard || rnd || sticky;
            case (c.mode)
                fdiv_pkg::RNE: up = guard && (rnd || sticky || sig[0]);
                fdiv_pkg::RDN: up = inexact && sign;
                fdiv_pkg::RUP: up = inexact && !sign;
                default:       up = 1'b0;
            endcase
            sig = sig + up;
            if (sig[24]) begin
                sig    = sig >> 1;
                biased = biased + 1;
            end
            r.flags.nx = inexact;
            if (biased >= 255) begin
                r.flags.of = 1'b1;
                r.flags.nx = 1'b1;
                if (c.mode == fdiv_pkg::RTZ || (c.mode == fdiv_pkg::RDN && !sign)
                        || (c.mode == fdiv_pkg::RUP && sign)) begin
                    r.value = {sign, 8'hfe, 23'h7f_ffff};
                end else begin
                    r.value = {sign, 8'hff, 23'd0};
                end
            end else if (biased <= 0) begin
                r.value    = {sign, 31'd0};
                r.flags.uf = 1'b1;
                r.flags.nx = 1'b1;
            end else begin
                r.value = {sign, biased[7:0], sig[22:0]};
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] make_normal(input int exp_lo, input int exp_hi);
        logic [31:0] v;
        int          e;
        e        = exp_lo + ({$random(seed)} % (exp_hi - exp_lo + 1));
        v        = $random(seed);
        v[30:23] = e[7:0];
        return v;
    endfunction

    function automatic logic [31:0] special_operand(input int idx);
        logic [31:0] v;
        case (idx)
            0:       v = 32'h0000_0000;
            1:       v = 32'h8000_0000;
            2:       v = 32'h0000_1234; // Subnormal.
            3:       v = 32'h7f80_0000;
            4:       v = 32'hff80_0000;
            5:       v = 32'h7fc0_0001;
            6:       v = 32'h7f80_0001; // Signalling NaN.
            7:       v = 32'h3fc0_0000;
            default: v = 32'hc040_0000;
        endcase
        return v;
    endfunction

    // Called 1 ns after a rising edge; returns at the same point of a later cycle.
    task automatic send_cmd(input logic [31:0] a, input logic [31:0] b,
                            input fdiv_pkg::fdiv_round_e mode);
        int   wait_cycles;
        int   gap;
        logic accepted;
        cmd.tag     = next_tag;
        cmd.a       = a;
        cmd.b       = b;
        cmd.mode    = mode;
        cmd_valid   = 1'b1;
        wait_cycles = 0;
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = cmd_ready;
            @(posedge clk);
            #1;
            wait_cycles++;
            if (!accepted && wait_cycles >= 2000) begin
                abort_run("timeout: a command was not accepted within 2000 cycles");
            end
        end
        next_tag  = next_tag + 1'b1;
        cmd_valid = 1'b0;
        if (random_gaps) begin
            gap = {$random(seed)} % 4;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    always @(posedge clk) begin
        #1;
        res_ready = random_ready ? next_ready : 1'b1;
    end

    // Scoreboard and handshake monitor sample at the falling edge.
    always @(negedge clk) begin : monitor
        fdiv_pkg::fdiv_result_t expected;
        if (rst_n === 1'b1) begin
            if (stall_seen) begin
                compare_value("res_valid", 32'd1, res_valid);
                compare_value("res.tag", held_res.tag, res.tag);
                compare_value("res.value", held_res.value, res.value);
                compare_flags("res.flags", held_res.flags, res.flags);
            end
            if (res_valid && res_ready) begin
                if (expected_q.size() == 0) begin
                    abort_run("a result arrived while no command was pending");
                end
                expected = expected_q.pop_front();
                compare_value("res.tag", expected.tag, res.tag);
                compare_value("res.value", expected.value, res.value);
                compare_flags("res.flags", expected.flags, res.flags);
            end
            stall_seen = res_valid && !res_ready;
            held_res   = res;
            if (cmd_valid && cmd_ready) begin
                expected_q.push_back(model_divide(cmd));
            end
        end
        next_ready = ($random(seed) & 1) != 0;
    end

    initial begin
        int                    i;
        int                    j;
        int                    ea;
        int                    wait_cycles;
        logic [31:0]           op_a;
        logic [31:0]           op_b;
        fdiv_pkg::fdiv_round_e mode;
        clk          = 1'b0;
        rst_n        = 1'b0;
        cmd_valid    = 1'b0;
        cmd          = '0;
        res_ready    = 1'b1;
        seed         = 32'hdd3b_aafb;
        random_ready = 1'b0;
        random_gaps  = 1'b0;
        next_ready   = 1'b1;
        stall_seen   = 1'b0;
        next_tag     = '0;

        for (i = 0; i < 16; i++) begin
            @(negedge clk);
            compare_value("res_valid", 32'd0, res_valid);
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        compare_value("cmd_ready", 32'd1, cmd_ready);
        for (i = 0; i < 5; i++) begin
            compare_value("res_valid", 32'd0, res_valid);
            @(negedge clk);
        end
        @(posedge clk);
        #1;

        for (i = 0; i < 300; i++) begin
            op_a = make_normal(64, 191);
            op_b = make_normal(64, 191);
            send_cmd(op_a, op_b, fdiv_pkg::fdiv_round_e'(i % 4));
        end

        for (i = 0; i < 9; i++) begin
            for (j = 0; j < 9; j++) begin
                send_cmd(special_operand(i), special_operand(j),
                         fdiv_pkg::fdiv_round_e'((i + j) % 4));
            end
        end

        // Exponent differences around the overflow and underflow limits.
        for (i = 0; i < 30; i++) begin
            ea   = 200 + ({$random(seed)} % 54);
            op_a = make_normal(ea, ea);
            ea   = ea - 126 - ({$random(seed)} % 4);
            op_b = make_normal(ea, ea);
            send_cmd(op_a, op_b, fdiv_pkg::fdiv_round_e'(i % 4));
            ea   = 1 + ({$random(seed)} % 100);
            op_a = make_normal(ea, ea);
            ea   = ea + 124 + ({$random(seed)} % 4);
            op_b = make_normal(ea, ea);
            send_cmd(op_a, op_b, fdiv_pkg::fdiv_round_e'(i % 4));
        end
        for (i = 0; i < 8; i++) begin
            op_a = {i[0], 31'h7f7f_ffff};
            send_cmd(op_a, 32'h0080_0000, fdiv_pkg::fdiv_round_e'(i / 2));
            send_cmd(32'h0080_0000, op_a, fdiv_pkg::fdiv_round_e'(i / 2));
        end

        for (i = 0; i < 160; i++) begin
            if (i == 40) begin
                random_ready = 1'b1; // Back-pressure from here on.
                random_gaps  = 1'b1;
            end
            mode = fdiv_pkg::fdiv_round_e'({$random(seed)} % 4);
            if (i % 2 == 0) begin
                op_a = special_operand({$random(seed)} % 9);
                op_b = special_operand({$random(seed)} % 9);
            end else begin
                op_a = make_normal(40, 215);
                op_b = make_normal(40, 215);
            end
            send_cmd(op_a, op_b, mode);
        end

        wait_cycles = 0;
        while (expected_q.size() != 0 && wait_cycles < 2000) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (expected_q.size() != 0) begin
            abort_run($sformatf("timeout: %0d results still pending after 2000 cycles",
                                expected_q.size()));
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

//--- src.f
+incdir+source
source/fdiv_pkg.sv
source/fdiv_operand_decode.sv
source/fdiv_exponent.sv
source/fdiv_mantissa_divide.sv
source/fdiv_round_pack.sv
source/fdiv_unit.sv
test/fdiv_tb.sv

//--- Bender.yml
package:
  name: fdiv_unit

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/fdiv_pkg.sv
      - source/fdiv_operand_decode.sv
      - source/fdiv_exponent.sv
      - source/fdiv_mantissa_divide.sv
      - source/fdiv_round_pack.sv
      - source/fdiv_unit.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/fdiv_tb.sv
